// ==== design/fadd_cfg.svh ====
//----------------------------
// binary32 only, no double or extended format
// flag positions index a flags_t vector
//----------------------------
`ifndef FADD_CFG_SVH
`define FADD_CFG_SVH

// field widths of the binary32 word
`define FADD_EXP_W  8
`define FADD_FRAC_W 23

// guard, round and sticky below the fraction
`define FADD_GRS_W  3

// flag vector bit positions
`define FADD_FLAG_INV 0
`define FADD_FLAG_OVF 1
`define FADD_FLAG_INX 2

// canonical quiet NaN
`define FADD_QNAN       32'h7fc0_0000
// largest finite magnitude, sign bit clear
`define FADD_MAX_FINITE 32'h7f7f_ffff

`endif

// ==== design/fadd_pkg.sv ====
//----------------------------
// types shared by the adder datapath
// unlisted rounding codes act as truncate
//----------------------------
`include "fadd_cfg.svh"

package fadd_pkg;

  // sign, exponent, fraction
  typedef logic [`FADD_EXP_W+`FADD_FRAC_W:0] fp_word_t;

  // biased exponent
  typedef logic [`FADD_EXP_W-1:0] exp_t;

  // hidden one, fraction, guard, round, sticky
  typedef logic [`FADD_FRAC_W+`FADD_GRS_W:0] mant_ext_t;

  // extended significand plus carry-out
  typedef logic [`FADD_FRAC_W+`FADD_GRS_W+1:0] sum_t;

  typedef logic [`FADD_FLAG_INX:0] flags_t;

  typedef enum logic [2:0] {
    RND_TRUNC = 3'd0,
    RND_EVEN  = 3'd2,
    RND_PLUS  = 3'd3,
    RND_MINUS = 3'd4
  } rnd_mode_t;

endpackage

// ==== design/fadd_control.sv ====
//----------------------------
// exponent 0 counts as zero, denormals flushed
// special results bypass the datapath
//----------------------------
`timescale 1ns/1ns
`include "fadd_cfg.svh"

module fadd_control (
  input  logic                  clk,
  input  logic                  rst,
  input  fadd_pkg::fp_word_t    a,
  input  fadd_pkg::fp_word_t    b,
  input  logic                  sub,
  input  fadd_pkg::rnd_mode_t   rmode,
  input  logic                  en,
  output fadd_pkg::rnd_mode_t   s2_rmode,
  input  fadd_pkg::fp_word_t    round_word,
  input  logic                  round_ovf,
  input  logic                  round_inx,
  output fadd_pkg::fp_word_t    res,
  output fadd_pkg::flags_t      flags,
  output logic                  done
);

  localparam int SIGN_POS = `FADD_EXP_W + `FADD_FRAC_W;

  fadd_pkg::fp_word_t   b_eff;
  logic                 a_zero, a_inf, a_nan, a_snan;
  logic                 b_zero, b_inf, b_nan, b_snan;
  logic                 inf_cancel;
  logic                 zero_sign;
  logic                 spec;
  logic                 spec_inv;
  fadd_pkg::fp_word_t   spec_word;

  logic                 s1_valid, s2_valid;
  fadd_pkg::rnd_mode_t  s1_rmode;
  logic                 s1_spec, s2_spec;
  logic                 s1_inv, s2_inv;
  fadd_pkg::fp_word_t   s1_word, s2_word;

  // b with the subtract folded into its sign
  assign b_eff = {b[SIGN_POS] ^ sub, b[SIGN_POS-1:0]};

  assign a_zero = ~|a[`FADD_FRAC_W +: `FADD_EXP_W];
  assign a_inf  = &a[`FADD_FRAC_W +: `FADD_EXP_W] & ~|a[`FADD_FRAC_W-1:0];
  assign a_nan  = &a[`FADD_FRAC_W +: `FADD_EXP_W] & |a[`FADD_FRAC_W-1:0];
  assign a_snan = a_nan & ~a[`FADD_FRAC_W-1];
  assign b_zero = ~|b[`FADD_FRAC_W +: `FADD_EXP_W];
  assign b_inf  = &b[`FADD_FRAC_W +: `FADD_EXP_W] & ~|b[`FADD_FRAC_W-1:0];
  assign b_nan  = &b[`FADD_FRAC_W +: `FADD_EXP_W] & |b[`FADD_FRAC_W-1:0];
  assign b_snan = b_nan & ~b[`FADD_FRAC_W-1];

  assign inf_cancel = a_inf & b_inf & (a[SIGN_POS] ^ b_eff[SIGN_POS]);
  assign zero_sign  = (a[SIGN_POS] & b_eff[SIGN_POS]) |
                      ((a[SIGN_POS] ^ b_eff[SIGN_POS]) & (rmode == fadd_pkg::RND_MINUS));

  always_comb begin
    spec      = 1'b1;
    spec_inv  = 1'b0;
    spec_word = a;
    if (a_nan | b_nan | inf_cancel) begin
      spec_word = `FADD_QNAN;
      spec_inv  = a_snan | b_snan | inf_cancel;
    end else if (a_inf) begin
      spec_word = a;
    end else if (b_inf) begin
      spec_word = b_eff;
    end else if (a_zero & b_zero) begin
      spec_word = {zero_sign, {SIGN_POS{1'b0}}};
    end else if (b_zero) begin
      spec_word = a;
    end else if (a_zero) begin
      spec_word = b_eff;
    end else begin
      spec = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      s1_valid <= en;
      s2_valid <= s1_valid;
    end
  end

  // follows the datapath stages
  always_ff @(posedge clk) begin
    s1_rmode <= rmode;
    s1_spec  <= spec;
    s1_inv   <= spec_inv;
    s1_word  <= spec_word;
    s2_rmode <= s1_rmode;
    s2_spec  <= s1_spec;
    s2_inv   <= s1_inv;
    s2_word  <= s1_word;
  end

  assign res  = s2_spec ? s2_word : round_word;
  assign done = s2_valid;

  always_comb begin
    flags = '0;
    if (s2_spec) begin
      flags[`FADD_FLAG_INV] = s2_inv;
    end else begin
      flags[`FADD_FLAG_OVF] = round_ovf;
      flags[`FADD_FLAG_INX] = round_inx;
    end
  end

endmodule

// ==== design/fadd_align.sv ====
//----------------------------
// operands assumed normal here
// zero, inf and NaN handled in control
//----------------------------
`timescale 1ns/1ns
`include "fadd_cfg.svh"

module fadd_align (
  input  logic                 clk,
  input  logic                 rst,
  input  fadd_pkg::fp_word_t   a,
  input  fadd_pkg::fp_word_t   b,
  input  logic                 sub,
  output fadd_pkg::mant_ext_t  s1_mant_big,
  output fadd_pkg::mant_ext_t  s1_mant_small,
  output fadd_pkg::exp_t       s1_exp,
  output logic                 s1_sign,
  output logic                 s1_eff_sub
);

  localparam int MAG_W = `FADD_EXP_W + `FADD_FRAC_W;
  localparam int SIG_W = `FADD_FRAC_W + `FADD_GRS_W + 1;

  logic                 a_big;
  logic                 b_sign;
  fadd_pkg::fp_word_t   op_big;
  fadd_pkg::fp_word_t   op_small;
  fadd_pkg::exp_t       exp_diff;
  fadd_pkg::mant_ext_t  small_raw;
  fadd_pkg::mant_ext_t  small_shf;
  fadd_pkg::mant_ext_t  lost_mask;
  logic                 sticky;

  assign b_sign = b[MAG_W] ^ sub;

  // exponent and fraction compared as one magnitude
  assign a_big    = a[MAG_W-1:0] >= b[MAG_W-1:0];
  assign op_big   = a_big ? a : b;
  assign op_small = a_big ? b : a;

  assign exp_diff = op_big[`FADD_FRAC_W +: `FADD_EXP_W] -
                    op_small[`FADD_FRAC_W +: `FADD_EXP_W];

  assign small_raw = {1'b1, op_small[`FADD_FRAC_W-1:0], {`FADD_GRS_W{1'b0}}};
  assign small_shf = small_raw >> exp_diff;

  // bits pushed out by the shift, all of them once diff >= 27
  assign lost_mask = ~({SIG_W{1'b1}} << exp_diff);
  assign sticky    = |(small_raw & lost_mask);

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_sign    <= 1'b0;
      s1_eff_sub <= 1'b0;
    end else begin
      s1_sign    <= a_big ? a[MAG_W] : b_sign;
      s1_eff_sub <= a[MAG_W] ^ b_sign;
    end
  end

  always_ff @(posedge clk) begin
    s1_mant_big   <= {1'b1, op_big[`FADD_FRAC_W-1:0], {`FADD_GRS_W{1'b0}}};
    s1_mant_small <= {small_shf[SIG_W-1:1], small_shf[0] | sticky};
    s1_exp        <= op_big[`FADD_FRAC_W +: `FADD_EXP_W];
  end

endmodule

// ==== design/fadd_sum.sv ====
//----------------------------
// big >= small, so a subtract never goes negative
//----------------------------
`timescale 1ns/1ns

module fadd_sum (
  input  logic                 clk,
  input  logic                 rst,
  input  fadd_pkg::mant_ext_t  s1_mant_big,
  input  fadd_pkg::mant_ext_t  s1_mant_small,
  input  fadd_pkg::exp_t       s1_exp,
  input  logic                 s1_sign,
  input  logic                 s1_eff_sub,
  output fadd_pkg::sum_t       s2_sum,
  output fadd_pkg::exp_t       s2_exp,
  output logic                 s2_sign
);

  fadd_pkg::sum_t  addend;
  fadd_pkg::sum_t  sum_next;

  // two's complement of small on a subtract
  assign addend   = s1_eff_sub ? ~{1'b0, s1_mant_small} : {1'b0, s1_mant_small};
  assign sum_next = {1'b0, s1_mant_big} + addend + s1_eff_sub;

  always_ff @(posedge clk) begin
    if (rst) begin
      s2_exp  <= '0;
      s2_sign <= 1'b0;
    end else begin
      s2_exp  <= s1_exp;
      s2_sign <= s1_sign;
    end
  end

  always_ff @(posedge clk) begin
    s2_sum <= sum_next;
  end

endmodule

// ==== design/fadd_renorm.sv ====
//----------------------------
// norm_exp of 0 marks a tiny result
//----------------------------
`timescale 1ns/1ns
`include "fadd_cfg.svh"

module fadd_renorm (
  input  fadd_pkg::sum_t       s2_sum,
  input  fadd_pkg::exp_t       s2_exp,
  output fadd_pkg::mant_ext_t  norm_mant,
  output fadd_pkg::exp_t       norm_exp,
  output logic                 norm_zero
);

  localparam int SIG_W = `FADD_FRAC_W + `FADD_GRS_W + 1;

  fadd_pkg::exp_t  lz;

  // highest set bit wins
  always_comb begin
    lz = '0;
    for (int i = 0; i < SIG_W; i++) begin
      if (s2_sum[i]) begin
        lz = fadd_pkg::exp_t'(SIG_W - 1 - i);
      end
    end
  end

  assign norm_zero = ~|s2_sum;

  always_comb begin
    if (s2_sum[SIG_W]) begin
      // carry-out, fold the two low bits into sticky
      norm_mant = {s2_sum[SIG_W:2], s2_sum[1] | s2_sum[0]};
      norm_exp  = s2_exp + 1'b1;
    end else begin
      norm_mant = s2_sum[SIG_W-1:0] << lz;
      norm_exp  = (s2_exp > lz) ? s2_exp - lz : '0;
    end
  end

endmodule

// ==== design/fadd_round.sv ====
//----------------------------
// tiny results flush to a signed zero
// overflow result depends on the mode
//----------------------------
`timescale 1ns/1ns
`include "fadd_cfg.svh"

module fadd_round (
  input  fadd_pkg::mant_ext_t  norm_mant,
  input  fadd_pkg::exp_t       norm_exp,
  input  logic                 norm_zero,
  input  logic                 s2_sign,
  input  fadd_pkg::rnd_mode_t  s2_rmode,
  output fadd_pkg::fp_word_t   round_word,
  output logic                 round_ovf,
  output logic                 round_inx
);

  localparam int MAG_W = `FADD_EXP_W + `FADD_FRAC_W;
  localparam int SIG_W = `FADD_FRAC_W + `FADD_GRS_W + 1;

  logic                     lsb, guard, rs, any_lost;
  logic                     inc;
  logic                     to_inf;
  logic                     exp_ovf;
  logic [`FADD_FRAC_W+1:0]  rnd_sig;
  logic [`FADD_EXP_W:0]     rnd_exp;

  assign lsb      = norm_mant[`FADD_GRS_W];
  assign guard    = norm_mant[`FADD_GRS_W-1];
  assign rs       = |norm_mant[`FADD_GRS_W-2:0];
  assign any_lost = guard | rs;

  always_comb begin
    case (s2_rmode)
      fadd_pkg::RND_EVEN:  inc = guard & (rs | lsb);
      fadd_pkg::RND_PLUS:  inc = ~s2_sign & any_lost;
      fadd_pkg::RND_MINUS: inc = s2_sign & any_lost;
      default:             inc = 1'b0;
    endcase
  end

  // on a carry the fraction is already all zero
  assign rnd_sig = {1'b0, norm_mant[SIG_W-1:`FADD_GRS_W]} + inc;
  assign rnd_exp = {1'b0, norm_exp} + rnd_sig[`FADD_FRAC_W+1];
  assign exp_ovf = rnd_exp >= {1'b0, {`FADD_EXP_W{1'b1}}};

  assign to_inf = (s2_rmode == fadd_pkg::RND_EVEN) |
                  ((s2_rmode == fadd_pkg::RND_PLUS) & ~s2_sign) |
                  ((s2_rmode == fadd_pkg::RND_MINUS) & s2_sign);

  always_comb begin
    round_ovf  = 1'b0;
    round_inx  = any_lost;
    round_word = {s2_sign, rnd_exp[`FADD_EXP_W-1:0], rnd_sig[`FADD_FRAC_W-1:0]};
    if (norm_zero) begin
      // exact cancellation
      round_word = {s2_rmode == fadd_pkg::RND_MINUS, {MAG_W{1'b0}}};
      round_inx  = 1'b0;
    end else if (norm_exp == '0) begin
      round_word = {s2_sign, {MAG_W{1'b0}}};
      round_inx  = 1'b1;
    end else if (exp_ovf) begin
      round_ovf = 1'b1;
      round_inx = 1'b1;
      if (to_inf) begin
        round_word = {s2_sign, {`FADD_EXP_W{1'b1}}, {`FADD_FRAC_W{1'b0}}};
      end else begin
        round_word = {s2_sign, {MAG_W{1'b0}}} | `FADD_MAX_FINITE;
      end
    end
  end

endmodule

// ==== design/fadd_top.sv ====
//----------------------------
// two-edge latency, one issue per cycle
// res and flags valid only while done
//----------------------------
`timescale 1ns/1ns

module fadd_top (
  input  logic                  clk,
  input  logic                  rst,
  input  fadd_pkg::fp_word_t    a,
  input  fadd_pkg::fp_word_t    b,
  input  logic                  sub,
  input  fadd_pkg::rnd_mode_t   rmode,
  input  logic                  en,
  output fadd_pkg::fp_word_t    res,
  output fadd_pkg::flags_t      flags,
  output logic                  done
);

  fadd_pkg::mant_ext_t  s1_mant_big;
  fadd_pkg::mant_ext_t  s1_mant_small;
  fadd_pkg::exp_t       s1_exp;
  logic                 s1_sign;
  logic                 s1_eff_sub;

  fadd_pkg::sum_t       s2_sum;
  fadd_pkg::exp_t       s2_exp;
  logic                 s2_sign;
  fadd_pkg::rnd_mode_t  s2_rmode;

  fadd_pkg::mant_ext_t  norm_mant;
  fadd_pkg::exp_t       norm_exp;
  logic                 norm_zero;

  fadd_pkg::fp_word_t   round_word;
  logic                 round_ovf;
  logic                 round_inx;

  fadd_control u_control (
    .clk        (clk),
    .rst        (rst),
    .a          (a),
    .b          (b),
    .sub        (sub),
    .rmode      (rmode),
    .en         (en),
    .s2_rmode   (s2_rmode),
    .round_word (round_word),
    .round_ovf  (round_ovf),
    .round_inx  (round_inx),
    .res        (res),
    .flags      (flags),
    .done       (done)
  );

  fadd_align u_align (
    .clk           (clk),
    .rst           (rst),
    .a             (a),
    .b             (b),
    .sub           (sub),
    .s1_mant_big   (s1_mant_big),
    .s1_mant_small (s1_mant_small),
    .s1_exp        (s1_exp),
    .s1_sign       (s1_sign),
    .s1_eff_sub    (s1_eff_sub)
  );

  fadd_sum u_sum (
    .clk           (clk),
    .rst           (rst),
    .s1_mant_big   (s1_mant_big),
    .s1_mant_small (s1_mant_small),
    .s1_exp        (s1_exp),
    .s1_sign       (s1_sign),
    .s1_eff_sub    (s1_eff_sub),
    .s2_sum        (s2_sum),
    .s2_exp        (s2_exp),
    .s2_sign       (s2_sign)
  );

  fadd_renorm u_renorm (
    .s2_sum    (s2_sum),
    .s2_exp    (s2_exp),
    .norm_mant (norm_mant),
    .norm_exp  (norm_exp),
    .norm_zero (norm_zero)
  );

  fadd_round u_round (
    .norm_mant  (norm_mant),
    .norm_exp   (norm_exp),
    .norm_zero  (norm_zero),
    .s2_sign    (s2_sign),
    .s2_rmode   (s2_rmode),
    .round_word (round_word),
    .round_ovf  (round_ovf),
    .round_inx  (round_inx)
  );

endmodule

// ==== verification/tb_fadd.sv ====
//----------------------------
// stops at the first error
// expected values from an exact model
//----------------------------
`timescale 1ns/1ns
`include "fadd_cfg.svh"

module tb_fadd;

  localparam int          TIMEOUT  = 50;
  localparam int          EXPECT_W = 35;
  localparam logic [31:0] SEED     = 32'h69df6bd9;

  logic                 clk;
  logic                 rst;
  fadd_pkg::fp_word_t   a;
  fadd_pkg::fp_word_t   b;
  logic                 sub;
  fadd_pkg::rnd_mode_t  rmode;
  logic                 en;
  fadd_pkg::fp_word_t   res;
  fadd_pkg::flags_t     flags;
  logic                 done;

  // flags on top, word below
  logic [EXPECT_W-1:0]  pending[$];
  logic [EXPECT_W-1:0]  head;
  int                   results;
  int                   runs;
  logic                 done_prev;

  fadd_top uut (
    .clk   (clk),
    .rst   (rst),
    .a     (a),
    .b     (b),
    .sub   (sub),
    .rmode (rmode),
    .en    (en),
    .res   (res),
    .flags (flags),
    .done  (done)
  );

  always #5 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(input string name, input fadd_pkg::fp_word_t got,
                            input fadd_pkg::fp_word_t want);
    if (got !== want) begin
      abort_run($sformatf("Mismatch %s: got %h expected %h", name, got, want));
    end
  endtask

  task automatic check_flags(input string name, input fadd_pkg::flags_t got,
                             input fadd_pkg::flags_t want);
    if (got !== want) begin
      abort_run($sformatf("Mismatch %s: got %h expected %h", name, got, want));
    end
  endtask

  // exact sum of the scaled integers, rounded once
  function automatic logic [EXPECT_W-1:0] fadd_model(input fadd_pkg::fp_word_t x,
      input fadd_pkg::fp_word_t y, input logic s, input fadd_pkg::rnd_mode_t m);
    logic                sx, sy, sr;
    logic                x_nan, y_nan, x_inf, y_inf, inf_diff;
    logic                guard, rest, up, to_inf;
    int                  ex, ey, emin, p, er, sh;
    logic [299:0]        vx, vy, vr, kept, lost, half;
    logic [24:0]         sig;
    fadd_pkg::flags_t    f;
    fadd_pkg::fp_word_t  w;
    sx = x[31];
    sy = y[31] ^ s;
    ex = x[30:23];
    ey = y[30:23];
    f  = '0;
    x_nan = (ex == 255) && (x[22:0] != 0);
    y_nan = (ey == 255) && (y[22:0] != 0);
    x_inf = (ex == 255) && (x[22:0] == 0);
    y_inf = (ey == 255) && (y[22:0] == 0);
    inf_diff = x_inf && y_inf && (sx != sy);
    if (x_nan || y_nan || inf_diff) begin
      w = `FADD_QNAN;
      f[`FADD_FLAG_INV] = (x_nan && !x[22]) || (y_nan && !y[22]) || inf_diff;
    end else if (x_inf) begin
      w = x;
    end else if (y_inf) begin
      w = {sy, y[30:0]};
    end else if (ex == 0 && ey == 0) begin
      w = {(sx && sy) || ((sx != sy) && (m == fadd_pkg::RND_MINUS)), 31'b0};
    end else if (ey == 0) begin
      w = x;
    end else if (ex == 0) begin
      w = {sy, y[30:0]};
    end else begin
      emin = (ex < ey) ? ex : ey;
      vx = {276'b0, 1'b1, x[22:0]} << (ex - emin);
      vy = {276'b0, 1'b1, y[22:0]} << (ey - emin);
      if (sx == sy) begin
        vr = vx + vy;
        sr = sx;
      end else if (vx >= vy) begin
        vr = vx - vy;
        sr = sx;
      end else begin
        vr = vy - vx;
        sr = sy;
      end
      if (vr == 0) begin
        w = {m == fadd_pkg::RND_MINUS, 31'b0};
      end else begin
        p = 0;
        for (int i = 0; i < 300; i++) begin
          if (vr[i]) begin
            p = i;
          end
        end
        er = emin + p - 23;
        if (er < 1) begin
          // below the smallest normal
          w = {sr, 31'b0};
          f[`FADD_FLAG_INX] = 1'b1;
        end else begin
          guard = 1'b0;
          rest  = 1'b0;
          if (p > 23) begin
            sh    = p - 23;
            kept  = vr >> sh;
            lost  = vr & ~({300{1'b1}} << sh);
            half  = 300'b1 << (sh - 1);
            guard = (lost & half) != 0;
            rest  = (lost & ~half) != 0;
          end else begin
            kept = vr << (23 - p);
          end
          sig = kept[24:0];
          case (m)
            fadd_pkg::RND_EVEN:  up = guard && (rest || sig[0]);
            fadd_pkg::RND_PLUS:  up = !sr && (guard || rest);
            fadd_pkg::RND_MINUS: up = sr && (guard || rest);
            default:             up = 1'b0;
          endcase
          sig = sig + up;
          if (sig[24]) begin
            sig = sig >> 1;
            er  = er + 1;
          end
          f[`FADD_FLAG_INX] = guard || rest;
          if (er >= 255) begin
            to_inf = (m == fadd_pkg::RND_EVEN) || ((m == fadd_pkg::RND_PLUS) && !sr) ||
                     ((m == fadd_pkg::RND_MINUS) && sr);
            w = to_inf ? {sr, 8'hff, 23'b0} : (`FADD_MAX_FINITE | {sr, 31'b0});
            f[`FADD_FLAG_OVF] = 1'b1;
            f[`FADD_FLAG_INX] = 1'b1;
          end else begin
            w = {sr, er[7:0], sig[22:0]};
          end
        end
      end
    end
    return {f, w};
  endfunction

  function automatic fadd_pkg::fp_word_t rand_normal(input int center, input int spread);
    int          e;
    logic [31:0] r;
    e = center + int'($urandom % (2 * spread + 1)) - spread;
    if (e < 1) begin
      e = 1;
    end
    if (e > 254) begin
      e = 254;
    end
    r = $urandom;
    return {r[31], e[7:0], r[22:0]};
  endfunction

  task automatic issue_op(input fadd_pkg::fp_word_t x, input fadd_pkg::fp_word_t y,
                          input logic s, input fadd_pkg::rnd_mode_t m);
    @(posedge clk);
    a     <= x;
    b     <= y;
    sub   <= s;
    rmode <= m;
    en    <= 1'b1;
    pending.push_back(fadd_model(x, y, s, m));
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    en <= 1'b0;
  endtask

  task automatic wait_done(output int cycles);
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!done && cycles < TIMEOUT);
    if (!done) begin
      abort_run("timeout, done did not arrive");
    end
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (pending.size() != 0 && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (pending.size() != 0) begin
      abort_run("timeout, done did not arrive for every issued operation");
    end
  endtask

  task automatic run_single(input fadd_pkg::fp_word_t x, input fadd_pkg::fp_word_t y,
                            input logic s, input fadd_pkg::rnd_mode_t m);
    issue_op(x, y, s, m);
    idle_cycle();
    wait_drain();
  endtask

  task automatic special_set(input fadd_pkg::rnd_mode_t m);
    run_single(32'h7fc0_0001, 32'h3f80_0000, 1'b0, m);
    run_single(32'h7f80_0001, 32'h3f80_0000, 1'b0, m);
    run_single(32'h3f80_0000, 32'hffa0_0000, 1'b1, m);
    run_single(32'h7f80_0000, 32'h7fc0_0000, 1'b0, m);
    // inf minus inf, both ways of getting there
    run_single(32'h7f80_0000, 32'h7f80_0000, 1'b1, m);
    run_single(32'h7f80_0000, 32'hff80_0000, 1'b0, m);
    run_single(32'h7f80_0000, 32'h7f80_0000, 1'b0, m);
    run_single(32'h3f80_0000, 32'h7f80_0000, 1'b1, m);
    run_single(32'hff80_0000, 32'h40a0_0000, 1'b0, m);
    run_single(32'h0000_0000, 32'h4040_0000, 1'b1, m);
    run_single(32'hc040_0000, 32'h0000_0123, 1'b0, m);
    run_single(32'h0000_0000, 32'h0000_0000, 1'b0, m);
    run_single(32'h8000_0000, 32'h0000_0000, 1'b1, m);
    run_single(32'h0000_0000, 32'h0000_0000, 1'b1, m);
    run_single(32'h8000_0000, 32'h0000_0000, 1'b0, m);
  endtask

  // pops one expectation per done cycle
  always @(negedge clk) begin
    if (done && !done_prev) begin
      runs++;
    end
    done_prev = done;
    if (done) begin
      if (pending.size() == 0) begin
        abort_run("done was high with no operation in flight");
      end else begin
        head = pending.pop_front();
        check_word("res", res, head[31:0]);
        check_flags("flags", flags, head[EXPECT_W-1:32]);
        results++;
      end
    end
  end

  initial begin
    int                  cycles;
    int                  runs0;
    int                  results0;
    logic [31:0]         seed_sink;
    logic [31:0]         r;
    fadd_pkg::fp_word_t  x;
    fadd_pkg::fp_word_t  y;
    clk       = 1'b0;
    rst       = 1'b1;
    a         = '0;
    b         = '0;
    sub       = 1'b0;
    rmode     = fadd_pkg::RND_TRUNC;
    en        = 1'b0;
    results   = 0;
    runs      = 0;
    done_prev = 1'b0;
    seed_sink = $urandom(SEED);
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    repeat (10) begin
      @(negedge clk);
      if (done !== 1'b0) begin
        abort_run("done went high while en was low");
      end
    end

    // single issue, done two edges after the sampling edge
    issue_op(32'h3f80_0000, 32'h4000_0000, 1'b0, fadd_pkg::RND_EVEN);
    idle_cycle();
    wait_done(cycles);
    if (cycles != 2) begin
      abort_run($sformatf("done came %0d edges after issue instead of 2", cycles));
    end
    @(negedge clk);
    if (done) begin
      abort_run("done stayed high for more than one cycle");
    end
    wait_drain();

    for (int code = 0; code < 8; code++) begin
      for (int n = 0; n < 80; n++) begin
        x = rand_normal(127, 40);
        y = rand_normal(x[30:23], ($urandom % 4 == 0) ? 126 : 26);
        issue_op(x, y, $urandom % 2, fadd_pkg::rnd_mode_t'(code[2:0]));
      end
      idle_cycle();
      wait_drain();
    end

    runs0    = runs;
    results0 = results;
    for (int n = 0; n < 40; n++) begin
      r = $urandom;
      issue_op(rand_normal(127, 20), rand_normal(127, 20), r[3],
               fadd_pkg::rnd_mode_t'(r[2:0]));
    end
    idle_cycle();
    wait_drain();
    if (runs != runs0 + 1 || results != results0 + 40) begin
      abort_run("a burst of 40 issues did not give 40 back-to-back done cycles");
    end

    for (int code = 0; code < 8; code++) begin
      special_set(fadd_pkg::rnd_mode_t'(code[2:0]));
      run_single(32'h7f7f_ffff, 32'h7f7f_ffff, 1'b0, fadd_pkg::rnd_mode_t'(code[2:0]));
      run_single(32'hff7f_ffff, 32'hff7f_ffff, 1'b0, fadd_pkg::rnd_mode_t'(code[2:0]));
      run_single(32'h7f7f_ffff, 32'h7300_0000, 1'b0, fadd_pkg::rnd_mode_t'(code[2:0]));
      run_single(32'hff7f_ffff, 32'h7300_0000, 1'b1, fadd_pkg::rnd_mode_t'(code[2:0]));
      run_single(32'h7f00_0000, 32'h7f00_0000, 1'b0, fadd_pkg::rnd_mode_t'(code[2:0]));
      run_single(32'h00c0_0000, 32'h0080_0000, 1'b1, fadd_pkg::rnd_mode_t'(code[2:0]));
      run_single(32'h80c0_0000, 32'h0080_0000, 1'b0, fadd_pkg::rnd_mode_t'(code[2:0]));
    end

    // near and exact cancellation, low exponents go tiny
    for (int n = 0; n < 300; n++) begin
      r = $urandom;
      x = rand_normal(r[8] ? 3 : 120, 2);
      case (r[5:4])
        2'd0: y = x ^ ($urandom % 64);
        2'd1: begin
          y = x + 32'h0080_0000;
          y[22:0] = r[31:9];
        end
        default: y = x;
      endcase
      issue_op(x, y, 1'b1, fadd_pkg::rnd_mode_t'(r[2:0]));
    end
    idle_cycle();
    wait_drain();

    $display("** PASS **");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+design
design/fadd_pkg.sv
design/fadd_control.sv
design/fadd_align.sv
design/fadd_sum.sv
design/fadd_renorm.sv
design/fadd_round.sv
design/fadd_top.sv
verification/tb_fadd.sv
